/* rtl/cache_macros.svh */
// ====================
// Geometry of the two-way data cache: 256 sets of 16-byte lines
// Bank width and the 3-bit victim LFSR assume four words per line
// ====================
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// Address split: tag | index | byte offset
`define CACHE_INDEX_W   8
`define CACHE_TAG_W     20
`define CACHE_OFFSET_W  4

// Line layout
`define CACHE_BANKS     4
`define CACHE_WORD_W    32
`define CACHE_STRB_W    4
`define CACHE_LINE_W    128

// Victim LFSR reset value, must be nonzero
`define CACHE_LFSR_SEED 3'b111

`endif

/* rtl/cache_pkg.sv */
// ====================
// Types shared by the cache RTL, sized from cache_macros.svh
// ====================
`default_nettype none

`include "cache_macros.svh"

package cache_pkg;

    typedef logic [`CACHE_INDEX_W-1:0]       index_t;
    typedef logic [`CACHE_TAG_W-1:0]         tag_t;
    typedef logic [`CACHE_OFFSET_W-1:0]      offset_t;
    typedef logic [$clog2(`CACHE_BANKS)-1:0] bank_t;    // Word within a line
    typedef logic [`CACHE_WORD_W-1:0]        word_t;
    typedef logic [`CACHE_STRB_W-1:0]        strb_t;
    typedef logic [`CACHE_LINE_W-1:0]        line_t;
    typedef logic [`CACHE_TAG_W+`CACHE_INDEX_W+`CACHE_OFFSET_W-1:0] addr_t;

    // Main controller
    typedef enum logic [2:0] {IDLE, LOOKUP, MISS, REPLACE, REFILL} main_state_e;

    // Hit write buffer
    typedef enum logic {WB_IDLE, WB_WRITE} wb_state_e;

endpackage

`default_nettype wire

/* rtl/hit_write_buffer.sv */
// ====================
// One-entry buffer that commits a store hit one cycle after lookup
// ====================
`timescale 1ns/100ps
`default_nettype none

module hit_write_buffer (
    input  wire                    clk,
    input  wire                    resetn,
    input  wire                    hit_write,
    input  wire                    hit_way,
    input  wire cache_pkg::bank_t  hit_bank,
    input  wire cache_pkg::index_t hit_index,
    input  wire cache_pkg::strb_t  hit_strb,
    input  wire cache_pkg::word_t  hit_word,
    output logic                   busy,
    output logic                   wr_en,
    output logic                   wr_way,
    output cache_pkg::bank_t       wr_bank,
    output cache_pkg::index_t      wr_index,
    output cache_pkg::strb_t       wr_strb,
    output cache_pkg::word_t       wr_word
);

    cache_pkg::wb_state_e state;

    // Back-to-back store hits keep the buffer in WB_WRITE
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= cache_pkg::WB_IDLE;
        end else begin
            state <= hit_write ? cache_pkg::WB_WRITE : cache_pkg::WB_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (hit_write) begin
            wr_way   <= hit_way;
            wr_bank  <= hit_bank;
            wr_index <= hit_index;
            wr_strb  <= hit_strb;
            wr_word  <= hit_word;
        end
    end

    assign busy  = (state == cache_pkg::WB_WRITE);
    assign wr_en = busy;     // Also sets the dirty bit

endmodule

`default_nettype wire

/* rtl/tag_dirty_array.sv */
// ====================
// Tag, valid and dirty state of both ways, registered read
// Outputs hold while rd_en is low
// ====================
`timescale 1ns/100ps
`default_nettype none

`include "cache_macros.svh"

module tag_dirty_array (
    input  wire                    clk,
    input  wire                    resetn,
    input  wire                    rd_en,
    input  wire cache_pkg::index_t rd_index,
    input  wire                    refill_we,
    input  wire                    refill_way,
    input  wire cache_pkg::index_t refill_index,
    input  wire cache_pkg::tag_t   refill_tag,
    input  wire                    refill_dirty,
    input  wire                    dirty_set,
    input  wire                    dirty_way,
    input  wire cache_pkg::index_t dirty_index,
    output cache_pkg::tag_t [1:0]  way_tag,
    output logic [1:0]             way_valid,
    output logic [1:0]             way_dirty
);

    localparam int SETS = 1 << `CACHE_INDEX_W;

    cache_pkg::tag_t tag_mem [2][SETS];
    logic [SETS-1:0] valid_q [2];
    logic [SETS-1:0] dirty_q [2];

    // Tag RAM, one per way
    always_ff @(posedge clk) begin
        if (refill_we) begin
            tag_mem[refill_way][refill_index] <= refill_tag;
        end
        if (rd_en) begin
            for (int w = 0; w < 2; w++) begin
                way_tag[w] <= tag_mem[w][rd_index];
            end
        end
    end

    // Valid and dirty bit tables
    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int w = 0; w < 2; w++) begin
                valid_q[w] <= '0;
                dirty_q[w] <= '0;
            end
            way_valid <= '0;
            way_dirty <= '0;
        end else begin
            if (dirty_set) begin
                dirty_q[dirty_way][dirty_index] <= 1'b1;
            end
            if (refill_we) begin                // New line, dirty only for a store miss
                valid_q[refill_way][refill_index] <= 1'b1;
                dirty_q[refill_way][refill_index] <= refill_dirty;
            end
            if (rd_en) begin
                for (int w = 0; w < 2; w++) begin
                    way_valid[w] <= valid_q[w][rd_index];
                    way_dirty[w] <= dirty_q[w][rd_index];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/data_bank_array.sv */
// ====================
// Data RAM: two ways of four byte-writable word banks
// Store commits may overlap a lookup read of the same bank
// ====================
`timescale 1ns/100ps
`default_nettype none

`include "cache_macros.svh"

module data_bank_array (
    input  wire                    clk,
    input  wire                    rd_en,
    input  wire cache_pkg::index_t rd_index,
    // Store hit commit
    input  wire                    wr_en,
    input  wire                    wr_way,
    input  wire cache_pkg::bank_t  wr_bank,
    input  wire cache_pkg::index_t wr_index,
    input  wire cache_pkg::strb_t  wr_strb,
    input  wire cache_pkg::word_t  wr_word,
    // Refill beat, never at the same time as a commit
    input  wire                    refill_way,
    input  wire cache_pkg::bank_t  refill_bank,
    input  wire cache_pkg::index_t refill_index,
    input  wire cache_pkg::strb_t  refill_strb,
    input  wire cache_pkg::word_t  refill_word,
    output cache_pkg::line_t [1:0] way_line
);

    localparam int SETS = 1 << `CACHE_INDEX_W;

    cache_pkg::word_t  mem      [2][`CACHE_BANKS][SETS];
    cache_pkg::strb_t  bank_we  [2][`CACHE_BANKS];
    cache_pkg::index_t bank_idx [2][`CACHE_BANKS];
    cache_pkg::word_t  bank_din [2][`CACHE_BANKS];

    // Per-bank write port select
    always_comb begin
        logic hit_sel;
        logic fill_sel;
        for (int w = 0; w < 2; w++) begin
            for (int b = 0; b < `CACHE_BANKS; b++) begin
                hit_sel  = wr_en && (wr_way == w[0]) && (wr_bank == b[1:0]);
                fill_sel = (|refill_strb) && (refill_way == w[0]) && (refill_bank == b[1:0]);
                bank_we[w][b]  = hit_sel ? wr_strb : (fill_sel ? refill_strb : '0);
                bank_idx[w][b] = hit_sel ? wr_index : refill_index;
                bank_din[w][b] = hit_sel ? wr_word : refill_word;
            end
        end
    end

    // Lookups never overlap a refill, so the read of a victim line stays whole
    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            for (int b = 0; b < `CACHE_BANKS; b++) begin
                if (|bank_we[w][b]) begin
                    for (int i = 0; i < `CACHE_STRB_W; i++) begin
                        if (bank_we[w][b][i]) begin
                            mem[w][b][bank_idx[w][b]][8*i +: 8] <= bank_din[w][b][8*i +: 8];
                        end
                    end
                end
                if (rd_en) begin
                    way_line[w][b*`CACHE_WORD_W +: `CACHE_WORD_W] <= mem[w][b][rd_index];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/cache_ctrl.sv */
// ====================
// Main cache controller: lookup, hazard stalls, write-back, refill
// Victim is picked by LFSR bit 0, invalid ways get no preference
// ====================
`timescale 1ns/100ps
`default_nettype none

`include "cache_macros.svh"

module cache_ctrl (
    input  wire                          clk,
    input  wire                          resetn,
    input  wire                          valid,
    input  wire                          op,
    input  wire cache_pkg::index_t       index,
    input  wire cache_pkg::tag_t         tag,
    input  wire cache_pkg::offset_t      offset,
    input  wire cache_pkg::strb_t        wstrb,
    input  wire cache_pkg::word_t        wdata,
    output logic                         addr_ok,
    output logic                         data_ok,
    output cache_pkg::word_t             rdata,
    output logic                         rd_req,
    output cache_pkg::addr_t             rd_addr,
    input  wire                          rd_rdy,
    input  wire                          ret_valid,
    input  wire                          ret_last,
    input  wire cache_pkg::word_t        ret_data,
    output logic                         wr_req,
    output cache_pkg::addr_t             wr_addr,
    output cache_pkg::line_t             wr_data,
    input  wire                          wr_rdy,
    input  wire cache_pkg::tag_t [1:0]   way_tag,
    input  wire [1:0]                    way_valid,
    input  wire [1:0]                    way_dirty,
    input  wire cache_pkg::line_t [1:0]  way_line,
    input  wire                          wb_busy,
    input  wire cache_pkg::bank_t        wb_bank,
    input  wire cache_pkg::index_t       wb_index,
    output logic                         lookup_en,
    output cache_pkg::index_t            lookup_index,
    output logic                         refill_we,
    output logic                         refill_way,
    output cache_pkg::index_t            refill_index,
    output cache_pkg::tag_t              refill_tag,
    output logic                         refill_dirty,
    output cache_pkg::bank_t             refill_bank,
    output cache_pkg::word_t             refill_word,
    output cache_pkg::strb_t             refill_strb,
    output logic                         hit_write,
    output logic                         hit_way,
    output cache_pkg::bank_t             hit_bank,
    output cache_pkg::index_t            hit_index,
    output cache_pkg::strb_t             hit_strb,
    output cache_pkg::word_t             hit_word
);

    cache_pkg::main_state_e state;
    cache_pkg::main_state_e state_next;

    // Request buffer
    logic              req_op;
    cache_pkg::index_t req_index;
    cache_pkg::tag_t   req_tag;
    cache_pkg::bank_t  req_bank;
    cache_pkg::strb_t  req_wstrb;
    cache_pkg::word_t  req_wdata;

    logic [1:0]        way_hit;
    logic              cache_hit;
    logic              lookup_write_hit;
    logic              hazard;
    logic              victim_dirty;
    logic              replace_way;
    logic              beat;
    logic [2:0]        lfsr;
    cache_pkg::bank_t  refill_cnt;
    cache_pkg::bank_t  new_bank;
    cache_pkg::line_t  hit_line;
    cache_pkg::word_t  merged;

    assign new_bank = offset[`CACHE_OFFSET_W-1:2];

    assign way_hit[0] = way_valid[0] && (way_tag[0] == req_tag);
    assign way_hit[1] = way_valid[1] && (way_tag[1] == req_tag);
    assign cache_hit  = |way_hit;
    assign hit_line   = way_hit[1] ? way_line[1] : way_line[0];

    // Pending or about-to-be-buffered store blocks same set or same bank
    assign lookup_write_hit = (state == cache_pkg::LOOKUP) && req_op && cache_hit;
    assign hazard = (wb_busy && (index == wb_index || new_bank == wb_bank)) ||
                    (lookup_write_hit && (index == req_index || new_bank == req_bank));

    assign addr_ok = ((state == cache_pkg::IDLE) ||
                      (state == cache_pkg::LOOKUP && cache_hit)) && !hazard;
    assign lookup_en    = valid && addr_ok;
    assign lookup_index = index;

    always_ff @(posedge clk) begin
        if (lookup_en) begin
            req_op    <= op;
            req_index <= index;
            req_tag   <= tag;
            req_bank  <= new_bank;
            req_wstrb <= wstrb;
            req_wdata <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= cache_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        case (state)
            cache_pkg::IDLE:    state_next = lookup_en ? cache_pkg::LOOKUP : cache_pkg::IDLE;
            cache_pkg::LOOKUP: begin
                if (!cache_hit) begin
                    state_next = cache_pkg::MISS;
                end else begin
                    state_next = lookup_en ? cache_pkg::LOOKUP : cache_pkg::IDLE;
                end
            end
            cache_pkg::MISS:    state_next = (!victim_dirty || wr_rdy) ? cache_pkg::REPLACE
                                                                      : cache_pkg::MISS;
            cache_pkg::REPLACE: state_next = rd_rdy ? cache_pkg::REFILL : cache_pkg::REPLACE;
            cache_pkg::REFILL:  state_next = (beat && ret_last) ? cache_pkg::IDLE
                                                                : cache_pkg::REFILL;
            default:            state_next = cache_pkg::IDLE;
        endcase
    end

    // Victim LFSR, x^3 + x^2 + 1, steps once per refill
    always_ff @(posedge clk) begin
        if (!resetn) begin
            lfsr <= `CACHE_LFSR_SEED;
        end else if (beat && ret_last) begin
            lfsr <= {lfsr[1:0], lfsr[2] ^ lfsr[1]};
        end
    end

    // LFSR is stable through MISS, so the victim is too
    assign victim_dirty = way_valid[lfsr[0]] && way_dirty[lfsr[0]];

    always_ff @(posedge clk) begin
        if (state == cache_pkg::MISS) begin
            replace_way <= lfsr[0];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            refill_cnt <= '0;
        end else if (state == cache_pkg::REPLACE) begin
            refill_cnt <= '0;
        end else if (beat) begin
            refill_cnt <= refill_cnt + 1'b1;
        end
    end

    assign beat = (state == cache_pkg::REFILL) && ret_valid;

    // Store bytes override the returned word
    always_comb begin
        merged = ret_data;
        for (int i = 0; i < `CACHE_STRB_W; i++) begin
            if (req_wstrb[i]) begin
                merged[8*i +: 8] = req_wdata[8*i +: 8];
            end
        end
    end

    assign refill_word  = (req_op && refill_cnt == req_bank) ? merged : ret_data;
    assign refill_strb  = {`CACHE_STRB_W{beat}};
    assign refill_bank  = refill_cnt;
    assign refill_way   = replace_way;
    assign refill_index = req_index;
    assign refill_tag   = req_tag;
    assign refill_dirty = req_op;
    assign refill_we    = beat && ret_last;     // Tag, valid, dirty on last beat

    // Stores complete at lookup; read misses on the requested beat
    assign data_ok = ((state == cache_pkg::LOOKUP) && (cache_hit || req_op)) ||
                     (beat && !req_op && refill_cnt == req_bank);
    assign rdata   = (state == cache_pkg::REFILL) ? ret_data
                   : hit_line[req_bank*`CACHE_WORD_W +: `CACHE_WORD_W];

    assign hit_write = lookup_write_hit;
    assign hit_way   = way_hit[1];
    assign hit_bank  = req_bank;
    assign hit_index = req_index;
    assign hit_strb  = req_wstrb;
    assign hit_word  = req_wdata;

    assign wr_req  = (state == cache_pkg::MISS) && victim_dirty;
    assign wr_addr = {way_tag[lfsr[0]], req_index, {`CACHE_OFFSET_W{1'b0}}};
    assign wr_data = way_line[lfsr[0]];     // Held at the RAM outputs since lookup

    assign rd_req  = (state == cache_pkg::REPLACE);
    assign rd_addr = {req_tag, req_index, {`CACHE_OFFSET_W{1'b0}}};

endmodule

`default_nettype wire

/* rtl/cache_top.sv */
// ====================
// Two-way write-back, write-allocate data cache
// Bus requests are always full lines, four beats on refill
// ====================
`timescale 1ns/100ps
`default_nettype none

module cache_top (
    input  wire                     clk,
    input  wire                     resetn,
    // CPU side
    input  wire                     valid,
    input  wire                     op,         // 1 for write
    input  wire cache_pkg::index_t  index,
    input  wire cache_pkg::tag_t    tag,
    input  wire cache_pkg::offset_t offset,
    input  wire cache_pkg::strb_t   wstrb,
    input  wire cache_pkg::word_t   wdata,
    output logic                    addr_ok,
    output logic                    data_ok,
    output cache_pkg::word_t        rdata,
    // Bus read
    output logic                    rd_req,
    output cache_pkg::addr_t        rd_addr,
    input  wire                     rd_rdy,
    input  wire                     ret_valid,
    input  wire                     ret_last,
    input  wire cache_pkg::word_t   ret_data,
    // Bus write
    output logic                    wr_req,
    output cache_pkg::addr_t        wr_addr,
    output cache_pkg::line_t        wr_data,
    input  wire                     wr_rdy
);

    logic                          lookup_en;
    cache_pkg::index_t             lookup_index;
    logic                          refill_we;
    logic                          refill_way;
    cache_pkg::index_t             refill_index;
    cache_pkg::tag_t               refill_tag;
    logic                          refill_dirty;
    cache_pkg::bank_t              refill_bank;
    cache_pkg::word_t              refill_word;
    cache_pkg::strb_t              refill_strb;
    logic                          hit_write;
    logic                          hit_way;
    cache_pkg::bank_t              hit_bank;
    cache_pkg::index_t             hit_index;
    cache_pkg::strb_t              hit_strb;
    cache_pkg::word_t              hit_word;
    logic                          wb_busy;
    logic                          wb_en;
    logic                          wb_way;
    cache_pkg::bank_t              wb_bank;
    cache_pkg::index_t             wb_index;
    cache_pkg::strb_t              wb_strb;
    cache_pkg::word_t              wb_word;
    cache_pkg::tag_t [1:0]         way_tag;
    logic [1:0]                    way_valid;
    logic [1:0]                    way_dirty;
    cache_pkg::line_t [1:0]        way_line;

    cache_ctrl u_ctrl (
        .clk, .resetn, .valid, .op, .index, .tag, .offset, .wstrb, .wdata,
        .addr_ok, .data_ok, .rdata,
        .rd_req, .rd_addr, .rd_rdy, .ret_valid, .ret_last, .ret_data,
        .wr_req, .wr_addr, .wr_data, .wr_rdy,
        .way_tag, .way_valid, .way_dirty, .way_line,
        .wb_busy, .wb_bank, .wb_index,
        .lookup_en, .lookup_index,
        .refill_we, .refill_way, .refill_index, .refill_tag, .refill_dirty,
        .refill_bank, .refill_word, .refill_strb,
        .hit_write, .hit_way, .hit_bank, .hit_index, .hit_strb, .hit_word
    );

    hit_write_buffer u_wbuf (
        .clk, .resetn,
        .hit_write, .hit_way, .hit_bank, .hit_index, .hit_strb, .hit_word,
        .busy     (wb_busy),
        .wr_en    (wb_en),
        .wr_way   (wb_way),
        .wr_bank  (wb_bank),
        .wr_index (wb_index),
        .wr_strb  (wb_strb),
        .wr_word  (wb_word)
    );

    tag_dirty_array u_tags (
        .clk, .resetn,
        .rd_en       (lookup_en),
        .rd_index    (lookup_index),
        .refill_we, .refill_way, .refill_index, .refill_tag, .refill_dirty,
        .dirty_set   (wb_en),       // Store hit commit marks the line dirty
        .dirty_way   (wb_way),
        .dirty_index (wb_index),
        .way_tag, .way_valid, .way_dirty
    );

    data_bank_array u_data (
        .clk,
        .rd_en    (lookup_en),
        .rd_index (lookup_index),
        .wr_en    (wb_en),
        .wr_way   (wb_way),
        .wr_bank  (wb_bank),
        .wr_index (wb_index),
        .wr_strb  (wb_strb),
        .wr_word  (wb_word),
        .refill_way, .refill_bank, .refill_index, .refill_strb, .refill_word,
        .way_line
    );

endmodule

`default_nettype wire

/* testbench/cache_asserts.sv */
// ====================
// Reset and bus protocol checks, bound into cache_top
// Bus checks are off while resetn is low
// ====================
`timescale 1ns/100ps
`default_nettype none

module cache_asserts (
    input wire                   clk,
    input wire                   resetn,
    input wire                   addr_ok,
    input wire                   data_ok,
    input wire                   rd_req,
    input wire                   rd_rdy,
    input wire cache_pkg::addr_t rd_addr,
    input wire                   wr_req,
    input wire                   wr_rdy,
    input wire cache_pkg::addr_t wr_addr,
    input wire cache_pkg::line_t wr_data
);

    int fail_count = 0;

    // First cycle out of reset
    reset_state: assert property (@(posedge clk)
        $rose(resetn) |-> !rd_req && !wr_req && !data_ok && addr_ok)
        else begin
            fail_count++;
            $error("Bus request, data_ok or a closed CPU port right after reset");
        end

    rd_hold: assert property (@(posedge clk) disable iff (!resetn)
        rd_req && !rd_rdy |=> rd_req && $stable(rd_addr))
        else begin
            fail_count++;
            $error("Read request dropped or moved while waiting for rd_rdy");
        end

    wr_hold: assert property (@(posedge clk) disable iff (!resetn)   // Whole line held
        wr_req && !wr_rdy |=> wr_req && $stable(wr_addr) && $stable(wr_data))
        else begin
            fail_count++;
            $error("Write request dropped or changed while waiting for wr_rdy");
        end

endmodule

`default_nettype wire

/* testbench/cache_tb.sv */
// ====================
// Random test of cache_top against a shadow memory
// 3 tags over 2 sets force evictions; word accesses only
// ====================
`timescale 1ns/100ps
`default_nettype none

module cache_tb;

    localparam int PERIOD         = 40;
    localparam int NUM_OPS        = 400;
    localparam int TIMEOUT_CYCLES = NUM_OPS * 40;   // Miss with write-back is far below 40
    localparam logic [31:0] SEED  = 32'd99058;

    logic clk;
    logic resetn;
    logic valid;
    logic op;
    cache_pkg::index_t  index;
    cache_pkg::tag_t    tag;
    cache_pkg::offset_t offset;
    cache_pkg::strb_t   wstrb;
    cache_pkg::word_t   wdata;
    logic addr_ok;
    logic data_ok;
    cache_pkg::word_t rdata;
    logic rd_req;
    cache_pkg::addr_t rd_addr;
    logic rd_rdy;
    logic ret_valid;
    logic ret_last;
    cache_pkg::word_t ret_data;
    logic wr_req;
    cache_pkg::addr_t wr_addr;
    cache_pkg::line_t wr_data;
    logic wr_rdy;

    logic [31:0] lfsr_state = SEED;
    logic [31:0] bus_mem [logic [31:0]];            // Word address keyed
    logic [31:0] shadow  [logic [31:0]];
    logic        exp_write_q [$];
    logic [31:0] exp_addr_q  [$];
    logic [31:0] exp_data_q  [$];
    logic        exp_fast_q  [$];
    int          exp_cycle_q [$];
    int          cycle = 0;
    int          data_errors = 0;
    logic        last_was_read = 1'b0;

    cache_top dut (.*);

    bind cache_top cache_asserts u_asserts (
        .clk(clk), .resetn(resetn), .addr_ok(addr_ok), .data_ok(data_ok),
        .rd_req(rd_req), .rd_rdy(rd_rdy), .rd_addr(rd_addr),
        .wr_req(wr_req), .wr_rdy(wr_rdy), .wr_addr(wr_addr), .wr_data(wr_data)
    );

    // Fibonacci LFSR x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ (addr * 32'h9e37_79b9);
    endfunction

    function automatic logic [31:0] bus_word(input logic [31:0] addr);
        return bus_mem.exists(addr) ? bus_mem[addr] : fill_word(addr);
    endfunction

    function automatic logic [31:0] shadow_word(input logic [31:0] addr);
        return shadow.exists(addr) ? shadow[addr] : fill_word(addr);
    endfunction

    task automatic next_drive_slot();
        @(posedge clk);
        #1;
    endtask

    task automatic pick_operation();
        logic [31:0] r;
        r = take_bits(1);
        if (last_was_read && r[0]) begin
            op = 1'b0;                              // Same read again
        end else begin
            r = take_bits(1);
            op = r[0];
            r = take_bits(2);
            case (r[1:0])
                2'd0:    tag = 20'h00010;
                2'd1:    tag = 20'h00321;
                default: tag = 20'h8abcd;
            endcase
            r = take_bits(1);
            index = r[0] ? 8'h5a : 8'h05;
            r = take_bits(2);
            offset = {r[1:0], 2'b00};
            r = take_bits(4);
            wstrb = r[3:0];
            wdata = take_bits(32);
        end
        last_was_read = !op;
    endtask

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin : watchdog
        while (cycle < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle++;
        end
        $display("Timeout after %0d cycles with %0d requests still waiting for data_ok",
                 cycle, exp_write_q.size());
        $display("Some tests failed");
        $finish;
    end

    // Answers full-line reads and writes with random rdy and return delays
    initial begin : bus_model
        logic [31:0] r;
        logic [31:0] base;
        wait (resetn === 1'b1);
        forever begin
            @(negedge clk);
            if (wr_req) begin
                r = take_bits(2);
                repeat (r + 1) next_drive_slot();
                wr_rdy = 1'b1;
                @(negedge clk);
                for (int k = 0; k < 4; k++) begin
                    bus_mem[wr_addr + 32'(4 * k)] = wr_data[32*k +: 32];
                end
                next_drive_slot();
                wr_rdy = 1'b0;
            end else if (rd_req) begin
                r = take_bits(2);
                repeat (r + 1) next_drive_slot();
                rd_rdy = 1'b1;
                @(negedge clk);
                base = rd_addr;
                next_drive_slot();
                rd_rdy = 1'b0;
                r = take_bits(2);
                repeat (r) next_drive_slot();
                for (int b = 0; b < 4; b++) begin
                    ret_valid = 1'b1;
                    ret_last  = (b == 3);
                    ret_data  = bus_word(base + 32'(4 * b));
                    next_drive_slot();
                end
                ret_valid = 1'b0;
                ret_last  = 1'b0;
            end
        end
    end

    // Checks, all sampled at the falling edge
    initial begin : monitor
        logic [31:0] addr;
        logic [31:0] w;
        logic [31:0] exp_word;
        logic [127:0] exp_line;
        logic        is_write;
        logic        fast;
        int          acc_cycle;
        logic        prev_read = 1'b0;
        logic [31:0] prev_addr = '0;
        int          last_rd_req_cycle = -1;
        forever begin
            @(negedge clk);
            if (!resetn) continue;
            if (rd_req) last_rd_req_cycle = cycle;
            if (data_ok) begin
                assert (exp_write_q.size() > 0) else begin
                    $display("data_ok at cycle %0d without an outstanding request", cycle);
                    data_errors++;
                end
                if (exp_write_q.size() > 0) begin
                    is_write  = exp_write_q.pop_front();
                    addr      = exp_addr_q.pop_front();
                    exp_word  = exp_data_q.pop_front();
                    fast      = exp_fast_q.pop_front();
                    acc_cycle = exp_cycle_q.pop_front();
                    if (!is_write) begin
                        assert (rdata === exp_word) else begin
                            $display("MISMATCH rdata at %h: expected %h, actual %h",
                                     addr, exp_word, rdata);
                            data_errors++;
                        end
                    end
                    if (fast) begin
                        assert (cycle == acc_cycle + 1 && last_rd_req_cycle < acc_cycle) else begin
                            $display("Repeated read of %h did not hit in one cycle", addr);
                            data_errors++;
                        end
                    end
                end
            end
            if (valid && addr_ok) begin
                addr = {tag, index, offset};
                fast = !op && prev_read && (prev_addr == addr) && (exp_write_q.size() == 0);
                w = shadow_word(addr);
                if (op) begin
                    for (int i = 0; i < 4; i++) begin
                        if (wstrb[i]) w[8*i +: 8] = wdata[8*i +: 8];
                    end
                    shadow[addr] = w;
                end
                exp_write_q.push_back(op);
                exp_addr_q.push_back(addr);
                exp_data_q.push_back(w);
                exp_fast_q.push_back(fast);
                exp_cycle_q.push_back(cycle);
                prev_read = !op;
                prev_addr = addr;
            end
            if (rd_req && rd_rdy) begin
                assert (rd_addr[3:0] == 4'h0) else begin
                    $display("MISMATCH rd_addr[3:0]: expected 0, actual %h", rd_addr[3:0]);
                    data_errors++;
                end
            end
            if (wr_req && wr_rdy) begin
                for (int k = 0; k < 4; k++) begin
                    exp_line[32*k +: 32] = shadow_word(wr_addr + 32'(4 * k));
                end
                assert (wr_addr[3:0] == 4'h0 && wr_data === exp_line) else begin
                    $display("MISMATCH wr_data at %h: expected %h, actual %h",
                             wr_addr, exp_line, wr_data);
                    data_errors++;
                end
            end
        end
    end

    initial begin : stimulus
        logic [31:0] r;
        resetn    = 1'b0;
        valid     = 1'b0;
        op        = 1'b0;
        index     = '0;
        tag       = '0;
        offset    = '0;
        wstrb     = '0;
        wdata     = '0;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        wr_rdy    = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        resetn = 1'b1;
        for (int n = 0; n < NUM_OPS; n++) begin
            r = take_bits(2);
            if (r[1:0] == 2'd0) begin              // Occasional idle cycle
                valid = 1'b0;
                next_drive_slot();
            end
            pick_operation();
            valid = 1'b1;
            @(negedge clk);
            while (!addr_ok) @(negedge clk);
            next_drive_slot();
        end
        valid = 1'b0;
        while (exp_write_q.size() != 0 || !addr_ok) next_drive_slot();
        $display("Errors: %0d data checks, %0d protocol assertions",
                 data_errors, dut.u_asserts.fail_count);
        if (data_errors == 0 && dut.u_asserts.fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+rtl
rtl/cache_pkg.sv
rtl/hit_write_buffer.sv
rtl/tag_dirty_array.sv
rtl/data_bank_array.sv
rtl/cache_ctrl.sv
rtl/cache_top.sv
testbench/cache_asserts.sv
testbench/cache_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module cache_tb -f sim.f -o cache_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/cache_sim +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "All tests passed"; then
    exit 0
fi
exit 1
